//--- rtl/arch_pkg.sv
// Architecture constants for the execute stage
// Data and register widths, instruction word size and the
// dual-view operand B word handed on to writeback

package arch_pkg;

    // Widths
    // --------------------
    localparam int XLEN         = 32;              // Default data width
    localparam int REG_ADDR_W   = 5;               // GPR address
    localparam int TRAP_CAUSE_W = 6;               // Exception cause code
    localparam int ILEN         = 32;              // Instruction word
    localparam int SIZE_W       = 2;               // Encoded instruction size

    // Operand B as seen by writeback
    // --------------------
    // Normal instructions carry plain data here. A trapping
    // instruction reuses the same word to carry its cause, so
    // writeback decodes it one way or the other off s3_trap.
    typedef union packed {
        logic [XLEN-1:0] data;                     // Plain operand
        struct packed {
            logic [XLEN-TRAP_CAUSE_W-1:0] pad;     // Always zero
            logic [TRAP_CAUSE_W-1:0]      cause;   // Trap cause
        } trap;
    } opr_b_u;

endpackage

//--- rtl/uop_pkg.sv
// Micro-op encodings for the execute stage
// One-hot functional unit select and the per-unit op codes

package uop_pkg;

    // Functional unit select
    // --------------------
    localparam int FU_W     = 5;                   // One-hot select width
    localparam int P_FU_ALU = 0;                   // Integer ALU
    localparam int P_FU_MUL = 1;                   // Multiplier
    localparam int P_FU_LSU = 2;                   // Load/store
    localparam int P_FU_CFU = 3;                   // Control flow
    localparam int P_FU_CSR = 4;                   // CSR access

    localparam int UOP_W = 5;                      // Micro-op width

    // ALU ops
    // --------------------
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'h00;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'h01;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'h02;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'h03;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'h04;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'h05;
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'h06;
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'h07;
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'h08;
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'h09;

    // Multiplier ops
    localparam logic [UOP_W-1:0] MUL_MUL    = 5'h00; // Low half
    localparam logic [UOP_W-1:0] MUL_MULH   = 5'h01; // Signed x signed
    localparam logic [UOP_W-1:0] MUL_MULHSU = 5'h02; // Signed x unsigned
    localparam logic [UOP_W-1:0] MUL_MULHU  = 5'h03; // Unsigned x unsigned

    // Load/store flag bits within the uop
    localparam int LSU_LOAD  = 3;
    localparam int LSU_STORE = 4;

    // Control flow ops
    // --------------------
    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'b00001;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'b00010;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'b00011;
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'b00100;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'b00101;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'b00110;
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b01000; // Resolved branch
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b01001;
    localparam logic [UOP_W-1:0] CFU_JAL       = 5'b10000;
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'b10001;

endpackage

//--- rtl/exec_alu.sv
// Integer ALU
// Add, subtract, logic, shifts and set-less-than. The plain sum and
// the compare flags are always produced for branch and address use.

`timescale 1ns/1ps

module exec_alu
    import arch_pkg::*, uop_pkg::*;
#(
    parameter int XLEN = arch_pkg::XLEN
) (
    input  logic [UOP_W-1:0] i_uop,                // ALU micro-op
    input  logic [XLEN-1:0]  i_lhs,                // Left operand
    input  logic [XLEN-1:0]  i_rhs,                // Right operand
    output logic [XLEN-1:0]  o_result,             // Selected result
    output logic [XLEN-1:0]  o_add,                // Raw lhs + rhs
    output logic             o_eq,                 // lhs == rhs
    output logic             o_lt_signed,          // lhs < rhs, signed
    output logic             o_lt_unsigned         // lhs < rhs, unsigned
);

    localparam int SHAMT_W = $clog2(XLEN);         // Shift amount bits

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sub_result;
    logic [XLEN-1:0]    shl_result;
    logic [XLEN-1:0]    shr_result;

    // Shifter only handles RV32 shift fields
    if (SHAMT_W != 5) begin : g_shamt_chk
        $error("exec_alu shifter expects a five bit shift amount");
    end

    // Adders and compares
    // --------------------
    assign o_add         = i_lhs + i_rhs;          // Also used for jalr and addresses
    assign sub_result    = i_lhs - i_rhs;
    assign o_eq          = (i_lhs == i_rhs);
    assign o_lt_signed   = ($signed(i_lhs) < $signed(i_rhs));
    assign o_lt_unsigned = (i_lhs < i_rhs);

    // Shifter
    // --------------------
    assign shamt      = i_rhs[SHAMT_W-1:0];        // Upper rhs bits ignored
    assign shl_result = i_lhs << shamt;
    assign shr_result = (i_uop == ALU_SRA) ? XLEN'($signed(i_lhs) >>> shamt)
                                           : (i_lhs >> shamt);

    // Result select
    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = o_add;
            ALU_SUB:  o_result = sub_result;
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_SLL:  o_result = shl_result;
            ALU_SRL,
            ALU_SRA:  o_result = shr_result;       // Arith fill picked above
            ALU_SLT:  o_result = XLEN'(o_lt_signed);
            ALU_SLTU: o_result = XLEN'(o_lt_unsigned);
            default:  o_result = '0;               // Not an ALU op
        endcase
    end

endmodule

//--- rtl/exec_branch_unit.sv
// Branch and jump resolution
// Turns a conditional branch into taken / not-taken from the ALU
// flags and forms the jump target with bit 0 cleared

`timescale 1ns/1ps

module exec_branch_unit
    import arch_pkg::*, uop_pkg::*;
#(
    parameter int XLEN = arch_pkg::XLEN
) (
    input  logic [UOP_W-1:0] i_uop,                // CFU micro-op
    input  logic             i_eq,                 // From ALU compare
    input  logic             i_lt_signed,
    input  logic             i_lt_unsigned,
    input  logic [XLEN-1:0]  i_add,                // rs1 + imm for jalr
    input  logic [XLEN-1:0]  i_link_base,          // Precomputed jal target
    output logic [UOP_W-1:0] o_uop,                // Resolved micro-op
    output logic [XLEN-1:0]  o_target              // Jump target
);

    logic is_cond;
    logic taken;

    always_comb begin
        is_cond = 1'b1;
        taken   = 1'b0;
        case (i_uop)
            CFU_BEQ:  taken = i_eq;
            CFU_BNE:  taken = !i_eq;
            CFU_BLT:  taken = i_lt_signed;
            CFU_BGE:  taken = !i_lt_signed;
            CFU_BLTU: taken = i_lt_unsigned;
            CFU_BGEU: taken = !i_lt_unsigned;
            default:  is_cond = 1'b0;              // Jumps pass through
        endcase
    end

    assign o_uop = !is_cond ? i_uop :
                   taken    ? CFU_TAKEN : CFU_NOT_TAKEN;

    // Bit 0 always cleared, per jalr rules
    assign o_target = (i_uop == CFU_JALR) ? {i_add[XLEN-1:1], 1'b0}
                                          : {i_link_base[XLEN-1:1], 1'b0};

endmodule

//--- rtl/exec_multiplier.sv
// Iterative multiplier
// Unsigned shift-add over XLEN cycles on operand magnitudes, with the
// sign fixed on the way out. Handles mul, mulh, mulhsu and mulhu.

`timescale 1ns/1ps

module exec_multiplier
    import arch_pkg::*, uop_pkg::*;
#(
    parameter int XLEN = arch_pkg::XLEN
) (
    input  logic              g_clk,
    input  logic              i_reset,
    input  logic              i_flush,             // Abandon current op
    input  logic              i_start,             // Mul presented, not done
    input  logic              i_progress,          // Result taken this cycle
    input  logic [UOP_W-1:0]  i_uop,
    input  logic [XLEN-1:0]   i_rs1,
    input  logic [XLEN-1:0]   i_rs2,
    output logic              o_ready,             // Product valid
    output logic [2*XLEN-1:0] o_product            // Full signed/unsigned product
);

    localparam int CNT_W = $clog2(XLEN);

    logic              busy_q;
    logic              ready_q;
    logic [CNT_W-1:0]  count_q;
    logic              neg_q;                      // Negate final product
    logic [XLEN-1:0]   mcand_q;                    // Multiplicand magnitude
    logic [2*XLEN-1:0] acc_q;                      // {partial sum, multiplier}
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN:0]     step_sum;
    logic              load;

    // Sign correction
    // --------------------
    assign a_neg = (i_uop != MUL_MULHU) && i_rs1[XLEN-1];   // rs1 signed except mulhu
    assign b_neg = ((i_uop == MUL_MUL) || (i_uop == MUL_MULH)) && i_rs2[XLEN-1];
    assign a_mag = a_neg ? -i_rs1 : i_rs1;
    assign b_mag = b_neg ? -i_rs2 : i_rs2;

    assign load     = i_start && !busy_q && !ready_q;
    assign step_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

    // Control
    // --------------------
    always_ff @(posedge g_clk) begin
        if (i_reset || i_flush || i_progress) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            count_q <= '0;
        end else if (busy_q) begin
            count_q <= count_q + 1'b1;
            if (count_q == CNT_W'(XLEN-1)) begin   // Last partial product
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
            end
        end else if (load) begin
            busy_q  <= 1'b1;
            count_q <= '0;
        end
    end

    // Datapath, one multiplier bit per cycle
    always_ff @(posedge g_clk) begin
        if (load) begin
            mcand_q <= a_mag;
            acc_q   <= {{XLEN{1'b0}}, b_mag};
            neg_q   <= a_neg ^ b_neg;
        end else if (busy_q) begin
            acc_q <= {step_sum, acc_q[XLEN-1:1]};  // Add then shift right
        end
    end

    assign o_ready   = ready_q;
    assign o_product = neg_q ? -acc_q : acc_q;

    // Decode must hold the same multiply until it completes
    mul_hold_a: assert property (@(posedge g_clk) disable iff (i_reset || i_flush)
        busy_q && i_start |-> $stable({i_uop, i_rs1, i_rs2}));

endmodule

//--- rtl/exec_pipe_reg.sv
// Execute stage output register
// Single entry; loads on an accepted instruction and holds its
// contents while writeback is busy

`timescale 1ns/1ps

module exec_pipe_reg
    import arch_pkg::*, uop_pkg::*;
#(
    parameter int XLEN = arch_pkg::XLEN
) (
    input  logic                  g_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic                  i_valid,         // Load new entry
    input  logic                  i_busy,          // Writeback stalled
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_opr_a,
    input  opr_b_u                i_opr_b,
    input  logic [UOP_W-1:0]      i_uop,
    input  logic [FU_W-1:0]       i_fu,
    input  logic                  i_trap,
    input  logic [SIZE_W-1:0]     i_size,
    input  logic [ILEN-1:0]       i_instr,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic [XLEN-1:0]       o_opr_a,
    output opr_b_u                o_opr_b,
    output logic [UOP_W-1:0]      o_uop,
    output logic [FU_W-1:0]       o_fu,
    output logic                  o_trap,
    output logic [SIZE_W-1:0]     o_size,
    output logic [ILEN-1:0]       o_instr,
    output logic                  o_valid,
    output logic                  o_busy           // Cannot take a new entry
);

    assign o_busy = o_valid && i_busy;

    always_ff @(posedge g_clk) begin
        if (i_reset || i_flush) begin
            o_valid <= 1'b0;
        end else if (i_valid) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                       // Drained, nothing new
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (i_valid) begin
            o_rd    <= i_rd;
            o_opr_a <= i_opr_a;
            o_opr_b <= i_opr_b;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
            o_trap  <= i_trap;
            o_size  <= i_size;
            o_instr <= i_instr;
        end
    end

    // Stage must not load over an entry that writeback is stalling
    s3_hold_a: assert property (@(posedge g_clk) disable iff (i_reset)
        o_valid && i_busy |=> $stable({o_rd, o_opr_a, o_opr_b, o_uop,
                                       o_fu, o_trap, o_size, o_instr}));

endmodule

//--- rtl/exec_stage.sv
// Execute stage top level
// Routes one decoded instruction to ALU, multiplier, address, branch
// or CSR path, builds the stage-3 operands and registers them for
// writeback. Also drives the forwarding outputs.

`timescale 1ns/1ps

module exec_stage
    import arch_pkg::*, uop_pkg::*;
#(
    parameter int XLEN = arch_pkg::XLEN
) (
    input  logic                  g_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic                  i_s2_valid,
    input  logic [REG_ADDR_W-1:0] i_s2_rd,
    input  logic [XLEN-1:0]       i_s2_opr_a,
    input  logic [XLEN-1:0]       i_s2_opr_b,
    input  logic [XLEN-1:0]       i_s2_opr_c,
    input  logic [UOP_W-1:0]      i_s2_uop,
    input  logic [FU_W-1:0]       i_s2_fu,
    input  logic                  i_s2_trap,
    input  logic [SIZE_W-1:0]     i_s2_size,
    input  logic [ILEN-1:0]       i_s2_instr,
    input  logic                  i_s3_busy,
    output logic                  o_s2_busy,
    output logic [REG_ADDR_W-1:0] o_s3_rd,
    output logic [XLEN-1:0]       o_s3_opr_a,
    output opr_b_u                o_s3_opr_b,
    output logic [UOP_W-1:0]      o_s3_uop,
    output logic [FU_W-1:0]       o_s3_fu,
    output logic                  o_s3_trap,
    output logic [SIZE_W-1:0]     o_s3_size,
    output logic [ILEN-1:0]       o_s3_instr,
    output logic                  o_s3_valid,
    output logic [REG_ADDR_W-1:0] o_fwd_rd,
    output logic [XLEN-1:0]       o_fwd_wdata,
    output logic                  o_fwd_load,
    output logic                  o_fwd_csr
);

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   alu_add;
    logic              alu_eq, alu_lt_s, alu_lt_u;
    logic [UOP_W-1:0]  cfu_uop;
    logic [XLEN-1:0]   cfu_target;
    logic              mul_start, mul_ready;
    logic [2*XLEN-1:0] mul_product;
    logic [XLEN-1:0]   mul_result;
    logic              p_valid, p_busy;
    logic [XLEN-1:0]   n_opr_a;
    logic [XLEN-1:0]   n_opr_b_data;
    opr_b_u            n_opr_b;
    logic [UOP_W-1:0]  n_uop;

    assign fu_alu = i_s2_fu[P_FU_ALU];
    assign fu_mul = i_s2_fu[P_FU_MUL];
    assign fu_lsu = i_s2_fu[P_FU_LSU];
    assign fu_cfu = i_s2_fu[P_FU_CFU];
    assign fu_csr = i_s2_fu[P_FU_CSR];

    // Stall and progress
    // --------------------
    assign mul_start = i_s2_valid && fu_mul && !mul_ready;   // Still computing
    assign o_s2_busy = p_busy || mul_start;
    assign p_valid   = i_s2_valid && !o_s2_busy;             // Accepted this cycle

    // Functional units
    // --------------------
    exec_alu #(.XLEN(XLEN)) alu_i (
        .i_uop         (i_s2_uop),
        .i_lhs         (i_s2_opr_a),
        .i_rhs         (i_s2_opr_b),
        .o_result      (alu_result),
        .o_add         (alu_add),
        .o_eq          (alu_eq),
        .o_lt_signed   (alu_lt_s),
        .o_lt_unsigned (alu_lt_u)
    );

    exec_branch_unit #(.XLEN(XLEN)) cfu_i (
        .i_uop         (i_s2_uop),
        .i_eq          (alu_eq),
        .i_lt_signed   (alu_lt_s),
        .i_lt_unsigned (alu_lt_u),
        .i_add         (alu_add),
        .i_link_base   (i_s2_opr_c),               // jal target from decode
        .o_uop         (cfu_uop),
        .o_target      (cfu_target)
    );

    exec_multiplier #(.XLEN(XLEN)) mul_i (
        .g_clk      (g_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_start    (mul_start),
        .i_progress (p_valid),
        .i_uop      (i_s2_uop),
        .i_rs1      (i_s2_opr_a),
        .i_rs2      (i_s2_opr_b),
        .o_ready    (mul_ready),
        .o_product  (mul_product)
    );

    // mul wants the low half, every other variant the high half
    assign mul_result = (i_s2_uop == MUL_MUL) ? mul_product[XLEN-1:0]
                                              : mul_product[2*XLEN-1:XLEN];

    // Stage-3 operand build
    // --------------------
    assign n_opr_a = {XLEN{fu_alu}} & alu_result |
                     {XLEN{fu_mul}} & mul_result |
                     {XLEN{fu_lsu}} & alu_add    |       // Effective address
                     {XLEN{fu_cfu}} & cfu_target |
                     {XLEN{fu_csr}} & i_s2_opr_a ;

    assign n_opr_b_data = {XLEN{fu_mul}} & mul_product[2*XLEN-1:XLEN] |
                          {XLEN{fu_lsu}} & i_s2_opr_c |      // Store data
                          {XLEN{fu_csr}} & i_s2_opr_c ;      // CSR write value

    always_comb begin
        if (i_s2_trap) begin
            n_opr_b.trap.pad   = '0;
            n_opr_b.trap.cause = TRAP_CAUSE_W'(i_s2_rd);     // Decode puts cause in rd
        end else begin
            n_opr_b.data = n_opr_b_data;
        end
    end

    assign n_uop = fu_cfu ? cfu_uop : i_s2_uop;

    exec_pipe_reg #(.XLEN(XLEN)) pipe_i (
        .g_clk   (g_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_valid (p_valid),
        .i_busy  (i_s3_busy),
        .i_rd    (i_s2_rd),
        .i_opr_a (n_opr_a),
        .i_opr_b (n_opr_b),
        .i_uop   (n_uop),
        .i_fu    (i_s2_fu),
        .i_trap  (i_s2_trap),
        .i_size  (i_s2_size),
        .i_instr (i_s2_instr),
        .o_rd    (o_s3_rd),
        .o_opr_a (o_s3_opr_a),
        .o_opr_b (o_s3_opr_b),
        .o_uop   (o_s3_uop),
        .o_fu    (o_s3_fu),
        .o_trap  (o_s3_trap),
        .o_size  (o_s3_size),
        .o_instr (o_s3_instr),
        .o_valid (o_s3_valid),
        .o_busy  (p_busy)
    );

    // Forwarding, straight from the s2 side
    assign o_fwd_rd    = i_s2_rd;
    assign o_fwd_wdata = n_opr_a;
    assign o_fwd_load  = fu_lsu && i_s2_uop[LSU_LOAD];
    assign o_fwd_csr   = fu_csr;

    // Decode hands over exactly one memory direction
    lsu_dir_a: assert property (@(posedge g_clk) disable iff (i_reset)
        i_s2_valid && fu_lsu |-> i_s2_uop[LSU_LOAD] ^ i_s2_uop[LSU_STORE]);

endmodule

//--- bench/tb_exec_checks.svh
// Compare helpers and stimulus LFSR for the execute stage bench
// Included inside the bench module, bumps its error counter

`ifndef TB_EXEC_CHECKS_SVH
`define TB_EXEC_CHECKS_SVH

// Result compares
// --------------------
task automatic check_word(input string what, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_oprb(input string what, input opr_b_u got, input opr_b_u exp);
    if (got.data !== exp.data) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h (cause view %h)",
                 $time, what, got.data, exp.data, got.trap.cause);
    end
endtask

task automatic check_uop(input string what, input logic [UOP_W-1:0] got,
                         input logic [UOP_W-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_rd(input string what, input logic [REG_ADDR_W-1:0] got,
                        input logic [REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_fu(input string what, input logic [FU_W-1:0] got,
                        input logic [FU_W-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_size(input string what, input logic [SIZE_W-1:0] got,
                          input logic [SIZE_W-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

`endif

//--- bench/tb_exec_stage.sv
// Execute stage testbench
// Replays the case file through the decode handshake while writeback
// stalls at random, then checks every stage-3 result in order

`timescale 1ns/1ps

module tb_exec_stage
    import arch_pkg::*, uop_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int SETTLE     = 25;                // Sample point after falling edge
    localparam int N_COLS     = 10;                // Words per case line
    localparam int MAX_CASES  = 64;
    localparam int WAIT_LIMIT = 200;               // Cycles per wait loop

    logic                  g_clk, i_reset, i_flush;
    logic                  i_s2_valid, i_s2_trap, i_s3_busy;
    logic [REG_ADDR_W-1:0] i_s2_rd;
    logic [XLEN-1:0]       i_s2_opr_a, i_s2_opr_b, i_s2_opr_c;
    logic [UOP_W-1:0]      i_s2_uop;
    logic [FU_W-1:0]       i_s2_fu;
    logic [SIZE_W-1:0]     i_s2_size;
    logic [ILEN-1:0]       i_s2_instr;
    logic                  o_s2_busy, o_s3_valid, o_s3_trap;
    logic [REG_ADDR_W-1:0] o_s3_rd, o_fwd_rd;
    logic [XLEN-1:0]       o_s3_opr_a, o_fwd_wdata;
    opr_b_u                o_s3_opr_b;
    logic [UOP_W-1:0]      o_s3_uop;
    logic [FU_W-1:0]       o_s3_fu;
    logic [SIZE_W-1:0]     o_s3_size;
    logic [ILEN-1:0]       o_s3_instr;
    logic                  o_fwd_load, o_fwd_csr;

    int          error_count = 0;
    int          case_count  = 0;
    int          done_count  = 0;
    logic        hold_busy   = 1'b0;               // Pins writeback stalled
    logic [31:0] lfsr_q;
    logic [31:0] case_mem [0:MAX_CASES*N_COLS-1];

    // Results still owed by the stage, oldest first
    int                    exp_id[$];
    logic [XLEN-1:0]       exp_a[$];
    opr_b_u                exp_b[$];
    logic [UOP_W-1:0]      exp_uop[$];
    logic                  exp_trap[$];
    logic [ILEN-1:0]       exp_tag[$];
    logic [REG_ADDR_W-1:0] exp_rd[$];
    logic [FU_W-1:0]       exp_fu[$];
    logic [SIZE_W-1:0]     exp_size[$];

    `include "tb_exec_checks.svh"

    exec_stage #(.XLEN(XLEN)) exec_stage_i (.*);

    // Clock and writeback stall
    // --------------------
    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD/2) g_clk = ~g_clk;
    end

    initial begin
        lfsr_q    = 32'h4e57;
        i_s3_busy = 1'b0;
        forever begin
            @(negedge g_clk);
            lfsr_q    = lfsr_step(lfsr_q);         // One step per busy bit
            i_s3_busy = hold_busy | lfsr_q[0];
        end
    end

    // Writeback side
    // --------------------
    initial begin
        forever begin
            @(negedge g_clk);
            #(SETTLE);
            if (!i_reset && o_s3_valid && !i_s3_busy)
                take_result();                     // Transfer on coming edge
        end
    end

    task automatic take_result();
        int errs_before;
        int id;
        errs_before = error_count;
        if (exp_id.size() == 0) begin
            error_count++;
            $display("Stage-3 output appeared with nothing outstanding at %0t", $time);
        end else begin
            id = exp_id.pop_front();
            check_word("o_s3_opr_a", o_s3_opr_a, exp_a.pop_front());
            check_oprb("o_s3_opr_b", o_s3_opr_b, exp_b.pop_front());
            check_uop("o_s3_uop", o_s3_uop, exp_uop.pop_front());
            check_bit("o_s3_trap", o_s3_trap, exp_trap.pop_front());
            check_word("o_s3_instr", o_s3_instr, exp_tag.pop_front());  // Order tag
            check_rd("o_s3_rd", o_s3_rd, exp_rd.pop_front());
            check_fu("o_s3_fu", o_s3_fu, exp_fu.pop_front());
            check_size("o_s3_size", o_s3_size, exp_size.pop_front());
            done_count++;
            if (error_count == errs_before)
                $display("case %0d ok", id);
            else
                $display("case %0d mismatch", id);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("** FAIL **");
        $finish;
    endtask

    // Decode side, one case per call
    // --------------------
    task automatic present_case(input int idx, input logic expect_out);
        int     base;
        int     waited;
        opr_b_u ob;
        base = idx * N_COLS;
        @(negedge g_clk);
        i_s2_fu    = case_mem[base][FU_W-1:0];
        i_s2_uop   = case_mem[base+1][UOP_W-1:0];
        i_s2_opr_a = case_mem[base+2];
        i_s2_opr_b = case_mem[base+3];
        i_s2_opr_c = case_mem[base+4];
        i_s2_rd    = case_mem[base+5][REG_ADDR_W-1:0];
        i_s2_trap  = case_mem[base+6][0];
        i_s2_size  = SIZE_W'(idx);                 // Varies per case
        i_s2_instr = 32'h0000_1000 + idx;          // Identity tag
        i_s2_valid = 1'b1;
        waited     = 0;
        #(SETTLE);
        if (i_s2_fu[P_FU_MUL])
            check_bit("o_s2_busy on multiply", o_s2_busy, 1'b1);
        while (o_s2_busy) begin
            if (waited == WAIT_LIMIT)
                abort_run("o_s2_busy never fell");
            waited++;
            @(negedge g_clk);
            #(SETTLE);
        end
        // Accepted on the coming edge, forwarding must match now
        check_rd("o_fwd_rd", o_fwd_rd, i_s2_rd);
        check_bit("o_fwd_load", o_fwd_load,
                  (i_s2_fu == FU_W'(1 << P_FU_LSU)) && i_s2_uop[LSU_LOAD] &&
                  !i_s2_uop[LSU_STORE]);
        check_bit("o_fwd_csr", o_fwd_csr, i_s2_fu == FU_W'(1 << P_FU_CSR));
        if (!i_s2_trap)
            check_word("o_fwd_wdata", o_fwd_wdata, case_mem[base+7]);
        ob.data = case_mem[base+8];                // Trap lines hold the cause word
        if (expect_out) begin
            exp_id.push_back(idx);
            exp_a.push_back(case_mem[base+7]);
            exp_b.push_back(ob);
            exp_uop.push_back(case_mem[base+9][UOP_W-1:0]);
            exp_trap.push_back(i_s2_trap);
            exp_tag.push_back(i_s2_instr);
            exp_rd.push_back(i_s2_rd);
            exp_fu.push_back(i_s2_fu);
            exp_size.push_back(i_s2_size);
        end
    endtask

    // Main sequence
    // --------------------
    initial begin
        int waited;
        i_reset    = 1'b1;
        i_flush    = 1'b0;
        i_s2_valid = 1'b0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop   = '0;
        i_s2_fu    = '0;
        i_s2_trap  = 1'b0;
        i_s2_size  = '0;
        i_s2_instr = '0;
        $readmemh("bench/exec_cases.txt", case_mem);
        while (case_count < MAX_CASES && !$isunknown(case_mem[case_count*N_COLS]))
            case_count++;
        if (case_count == 0)
            abort_run("no cases found in bench/exec_cases.txt");

        repeat (5) @(posedge g_clk);
        @(negedge g_clk);
        i_reset = 1'b0;
        #(SETTLE);
        check_bit("o_s3_valid after reset", o_s3_valid, 1'b0);
        check_bit("o_s2_busy after reset", o_s2_busy, 1'b0);

        for (int i = 0; i < case_count; i++)
            present_case(i, 1'b1);
        @(negedge g_clk);
        i_s2_valid = 1'b0;

        waited = 0;                                // Drain under random stalls
        while (exp_id.size() != 0 || o_s3_valid) begin
            if (waited == WAIT_LIMIT)
                abort_run("stage-3 results never drained");
            waited++;
            @(negedge g_clk);
            #(SETTLE);
        end

        // Flush while writeback holds the entry
        hold_busy = 1'b1;
        present_case(0, 1'b0);
        @(negedge g_clk);
        i_s2_valid = 1'b0;
        i_flush    = 1'b1;
        #(SETTLE);
        check_bit("o_s3_valid before flush", o_s3_valid, 1'b1);
        @(negedge g_clk);
        i_flush = 1'b0;
        #(SETTLE);
        check_bit("o_s3_valid after flush", o_s3_valid, 1'b0);
        check_bit("o_s2_busy after flush", o_s2_busy, 1'b0);
        hold_busy = 1'b0;
        $display("flush check done");

        if (done_count != case_count) begin
            error_count++;
            $display("Only %0d of %0d cases came out of the stage", done_count, case_count);
        end
        $display("cases %0d, checked %0d, errors %0d", case_count, done_count, error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- src.f
+incdir+bench
rtl/arch_pkg.sv
rtl/uop_pkg.sv
rtl/exec_alu.sv
rtl/exec_branch_unit.sv
rtl/exec_multiplier.sv
rtl/exec_pipe_reg.sv
rtl/exec_stage.sv
bench/tb_exec_stage.sv

//--- bench/exec_cases.txt
// fu uop opr_a opr_b opr_c rd trap, then expected s3_opr_a s3_opr_b s3_uop
// all hex; fu one-hot 01 alu, 02 mul, 04 lsu, 08 cfu, 10 csr
01 00 00000005 00000007 00000000 01 0 0000000c 00000000 00
01 01 00000005 00000007 00000000 02 0 fffffffe 00000000 01
01 02 f0f01234 0ff04321 00000000 03 0 ff005115 00000000 02
01 03 f000000f 0f0000f0 00000000 04 0 ff0000ff 00000000 03
01 04 ffff0f0f 12345678 00000000 05 0 12340608 00000000 04
01 05 00000001 00000024 00000000 06 0 00000010 00000000 05
01 06 80000000 00000004 00000000 07 0 08000000 00000000 06
01 07 80000000 00000004 00000000 08 0 f8000000 00000000 07
01 08 ffffffff 00000001 00000000 09 0 00000001 00000000 08
01 09 ffffffff 00000001 00000000 0a 0 00000000 00000000 09
08 01 00000005 00000005 00001000 00 0 00001000 00000000 08
08 02 00000005 00000005 00001000 00 0 00001000 00000000 09
08 03 fffffffe 00000001 00001001 00 0 00001000 00000000 08
08 04 fffffffe 00000001 00001000 00 0 00001000 00000000 09
08 05 fffffffe 00000001 00001000 00 0 00001000 00000000 09
08 06 fffffffe 00000001 00001000 00 0 00001000 00000000 08
08 10 00000000 00000000 00002345 01 0 00002344 00000000 10
08 11 00001001 00000010 00000000 01 0 00001010 00000000 11
04 08 00001000 00000024 deadbeef 0b 0 00001024 deadbeef 08
04 10 20000000 fffffffc 12345678 00 0 1ffffffc 12345678 10
10 00 000000ff 00000000 cafef00d 0c 0 000000ff cafef00d 00
02 00 00000003 fffffffe 00000000 0d 0 fffffffa ffffffff 00
02 01 80000000 80000000 00000000 0e 0 40000000 40000000 01
02 02 ffffffff ffffffff 00000000 0f 0 ffffffff ffffffff 02
02 03 ffffffff ffffffff 00000000 10 0 fffffffe fffffffe 03
01 00 00000001 00000002 00000000 0c 1 00000003 0000000c 00
